/* hdl/risk_pkg.sv */
// Shared widths, reasons and stage payloads; quantities and prices are unsigned integers
package risk_pkg;

    // =========================================================================
    // Field widths
    // =========================================================================

    // Prices in integer ticks
    localparam int px_w = 32;
    // Order quantities
    localparam int qty_w = 32;
    // Free-running timestamp counter
    localparam int ts_w = 64;
    // Price band in basis points
    localparam int bps_w = 16;
    // One unit of price expressed in basis points
    localparam int unsigned bps_scale = 10000;

    // =========================================================================
    // Reject reasons
    // =========================================================================

    // Listed in priority order after accept
    typedef enum logic [3:0] {
        risk_accept         = 4'd0,
        risk_kill_switch    = 4'd1,
        risk_stale_data     = 4'd2,
        risk_seq_gap        = 4'd3,
        risk_price_band     = 4'd4,
        risk_token_bucket   = 4'd5,
        risk_position_limit = 4'd6
    } risk_reason_e;

    // =========================================================================
    // Inter-stage payloads
    // =========================================================================

    // Capture to checks
    typedef struct packed {
        logic [px_w-1:0]  mid_px;
        logic [qty_w-1:0] bid_qty;
        logic [qty_w-1:0] ask_qty;
        // Cycles since the book update
        logic [ts_w-1:0]  age;
        logic             stale;
        logic [ts_w-1:0]  decision_ts;
    } capture_payload_t;

    // Checks to decide
    typedef struct packed {
        logic             not_killed;
        logic             not_stale;
        logic             no_seq_gap;
        logic             band_ok;
        logic             position_ok;
        // Highest failure among the five, token check not yet merged
        risk_reason_e     reason;
        logic [ts_w-1:0]  decision_ts;
    } check_payload_t;

endpackage : risk_pkg

/* hdl/risk_pipe_stage.sv */
// One-entry valid/ready register; payload is not reset, only the valid flag is
`timescale 1ns/1ps

module risk_pipe_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_ready
);

    // Room when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    // =========================================================================
    // Valid flag
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload captured only on an input transfer
    // Held unchanged while stalled
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_payload <= in_payload;
        end
    end

endmodule : risk_pipe_stage

/* hdl/risk_capture.sv */
// Stage 1 event capture; no event is taken while cfg_enable is low, age wraps modulo 2^64
`timescale 1ns/1ps

module risk_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    // Book event
    input  logic [risk_pkg::px_w-1:0]     bid_px,
    input  logic [risk_pkg::px_w-1:0]     ask_px,
    input  logic [risk_pkg::qty_w-1:0]    bid_qty,
    input  logic [risk_pkg::qty_w-1:0]    ask_qty,
    input  logic [risk_pkg::ts_w-1:0]     book_ts,
    input  logic                          stale,
    input  logic                          event_valid,
    output logic                          event_ready,
    // Time reference and enable
    input  logic [risk_pkg::ts_w-1:0]     timestamp_cnt,
    input  logic                          cfg_enable,
    // Towards the checks stage
    output logic                          out_valid,
    output risk_pkg::capture_payload_t    out_payload,
    input  logic                          out_ready
);

    import risk_pkg::*;

    logic             stage_ready;
    logic [px_w:0]    px_sum;
    capture_payload_t cap_next;

    // Extra bit keeps the carry of the sum
    assign px_sum = {1'b0, bid_px} + {1'b0, ask_px};

    always_comb begin
        cap_next.mid_px      = px_sum[px_w:1];
        cap_next.bid_qty     = bid_qty;
        cap_next.ask_qty     = ask_qty;
        cap_next.age         = timestamp_cnt - book_ts;
        cap_next.stale       = stale;
        // Decision time is the capture time
        cap_next.decision_ts = timestamp_cnt;
    end

    // Gate closed while disabled
    assign event_ready = cfg_enable && stage_ready;

    risk_pipe_stage #(
        .payload_t (capture_payload_t)
    ) capture_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (event_valid && cfg_enable),
        .in_payload  (cap_next),
        .in_ready    (stage_ready),
        .out_valid   (out_valid),
        .out_payload (out_payload),
        .out_ready   (out_ready)
    );

endmodule : risk_capture

/* hdl/risk_checks.sv */
// Stage 2 checks; config levels are sampled at the load edge and must be quasi-static
`timescale 1ns/1ps

module risk_checks #(
    parameter int cycles_per_usec = 300
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  risk_pkg::capture_payload_t    in_payload,
    output logic                          in_ready,
    input  logic                          cfg_kill,
    input  logic [risk_pkg::px_w-1:0]     cfg_ref_price,
    input  logic [risk_pkg::bps_w-1:0]    cfg_price_band_bps,
    input  logic [risk_pkg::qty_w-1:0]    cfg_position_limit,
    input  logic [31:0]                   cfg_stale_usec,
    output logic                          out_valid,
    output risk_pkg::check_payload_t      out_payload,
    input  logic                          out_ready
);

    import risk_pkg::*;

    logic [ts_w-1:0]   stale_limit;
    logic [px_w-1:0]   px_diff;
    logic [2*px_w-1:0] band_lhs;
    logic [2*px_w-1:0] band_rhs;
    check_payload_t    chk_next;

    // Staleness limit in clock cycles
    assign stale_limit = ts_w'(cfg_stale_usec) * ts_w'(cycles_per_usec);

    // Absolute distance of mid from reference
    assign px_diff = (in_payload.mid_px >= cfg_ref_price) ? in_payload.mid_px - cfg_ref_price
                                                          : cfg_ref_price - in_payload.mid_px;

    // Cross-multiplied so no divide is needed
    assign band_lhs = (2*px_w)'(px_diff) * (2*px_w)'(bps_scale);
    assign band_rhs = (2*px_w)'(cfg_ref_price) * (2*px_w)'(cfg_price_band_bps);

    always_comb begin
        chk_next.not_killed  = !cfg_kill;
        chk_next.not_stale   = !in_payload.stale || (in_payload.age <= stale_limit);
        // Upstream stale flag doubles as the gap indication
        chk_next.no_seq_gap  = !in_payload.stale;
        // Zero reference or zero band disables the check
        chk_next.band_ok     = (cfg_ref_price == '0) || (cfg_price_band_bps == '0) ||
                               (band_lhs <= band_rhs);
        chk_next.position_ok = (in_payload.bid_qty <= cfg_position_limit) &&
                               (in_payload.ask_qty <= cfg_position_limit);
        chk_next.decision_ts = in_payload.decision_ts;

        // Priority encode, token slot filled in later
        if (!chk_next.not_killed) begin
            chk_next.reason = risk_kill_switch;
        end else if (!chk_next.not_stale) begin
            chk_next.reason = risk_stale_data;
        end else if (!chk_next.no_seq_gap) begin
            chk_next.reason = risk_seq_gap;
        end else if (!chk_next.band_ok) begin
            chk_next.reason = risk_price_band;
        end else if (!chk_next.position_ok) begin
            chk_next.reason = risk_position_limit;
        end else begin
            chk_next.reason = risk_accept;
        end
    end

    risk_pipe_stage #(
        .payload_t (check_payload_t)
    ) check_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_payload  (chk_next),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_payload (out_payload),
        .out_ready   (out_ready)
    );

endmodule : risk_checks

/* hdl/risk_token_bucket.sv */
// Token bucket, empty after reset; a refill only raises a bucket that sits below cfg_token_max
`timescale 1ns/1ps

module risk_token_bucket #(
    parameter int replenish_cycles = 300000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] cfg_token_rate,
    input  logic [15:0] cfg_token_max,
    input  logic        consume,
    output logic        token_ok
);

    localparam int cnt_w = (replenish_cycles > 1) ? $clog2(replenish_cycles) : 1;

    logic [cnt_w-1:0] tick_cnt;
    logic             tick;
    logic [15:0]      bucket;
    logic [16:0]      bucket_sum;
    logic [15:0]      bucket_refill;

    // Interval marker
    assign tick = (tick_cnt == cnt_w'(replenish_cycles - 1));

    // Saturating refill
    assign bucket_sum    = {1'b0, bucket} + {1'b0, cfg_token_rate};
    assign bucket_refill = (bucket >= cfg_token_max)            ? bucket :
                           (bucket_sum > {1'b0, cfg_token_max}) ? cfg_token_max :
                                                                  bucket_sum[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            bucket   <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            // Refill and spend may land on the same edge
            if (consume && token_ok) begin
                bucket <= (tick ? bucket_refill : bucket) - 16'd1;
            end else if (tick) begin
                bucket <= bucket_refill;
            end
        end
    end

    assign token_ok = (bucket != '0);

endmodule : risk_token_bucket

/* hdl/risk_decide.sv */
// Stage 3 decision register; tokens are spent when a decision is formed, not when delivered
`timescale 1ns/1ps

module risk_decide #(
    parameter int replenish_cycles = 300000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  risk_pkg::check_payload_t      in_payload,
    output logic                          in_ready,
    input  logic [15:0]                   cfg_token_rate,
    input  logic [15:0]                   cfg_token_max,
    output logic                          decision_valid,
    output logic                          decision_accept,
    output risk_pkg::risk_reason_e        decision_reason,
    output logic [risk_pkg::ts_w-1:0]     decision_ts,
    input  logic                          decision_ready,
    output logic [31:0]                   stat_accepts,
    output logic [31:0]                   stat_rejects
);

    import risk_pkg::*;

    logic         load;
    logic         token_ok;
    logic         early_ok;
    logic         accept_next;
    risk_reason_e reason_next;

    // Output register free or draining this cycle
    assign in_ready = !decision_valid || decision_ready;
    assign load     = in_valid && in_ready;

    // =========================================================================
    // Token merge
    // =========================================================================

    // Checks that outrank the token bucket
    assign early_ok = in_payload.not_killed && in_payload.not_stale &&
                      in_payload.no_seq_gap && in_payload.band_ok;

    assign accept_next = early_ok && token_ok && in_payload.position_ok;

    always_comb begin
        if (early_ok && !token_ok) begin
            reason_next = risk_token_bucket;
        end else begin
            // Earlier failure, position failure or accept
            reason_next = in_payload.reason;
        end
    end

    risk_token_bucket #(
        .replenish_cycles (replenish_cycles)
    ) token_bucket_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_token_rate (cfg_token_rate),
        .cfg_token_max  (cfg_token_max),
        .consume        (load && accept_next),
        .token_ok       (token_ok)
    );

    // =========================================================================
    // Decision register and counters
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decision_valid <= 1'b0;
            stat_accepts   <= '0;
            stat_rejects   <= '0;
        end else begin
            if (in_ready) begin
                decision_valid <= in_valid;
            end
            // Count on delivery only
            if (decision_valid && decision_ready) begin
                if (decision_accept) begin
                    stat_accepts <= stat_accepts + 32'd1;
                end else begin
                    stat_rejects <= stat_rejects + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            decision_accept <= accept_next;
            decision_reason <= reason_next;
            decision_ts     <= in_payload.decision_ts;
        end
    end

endmodule : risk_decide

/* hdl/risk_gate.sv */
// Three-stage risk gate; holds up to three events, decisions leave in input order
`timescale 1ns/1ps

module risk_gate #(
    parameter int replenish_cycles = 300000,
    parameter int cycles_per_usec  = 300
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Book event
    input  logic [risk_pkg::px_w-1:0]     bid_px,
    input  logic [risk_pkg::px_w-1:0]     ask_px,
    input  logic [risk_pkg::qty_w-1:0]    bid_qty,
    input  logic [risk_pkg::qty_w-1:0]    ask_qty,
    input  logic [risk_pkg::ts_w-1:0]     book_ts,
    input  logic                          stale,
    input  logic                          event_valid,
    output logic                          event_ready,
    input  logic [risk_pkg::ts_w-1:0]     timestamp_cnt,
    // Configuration levels
    input  logic                          cfg_enable,
    input  logic [risk_pkg::px_w-1:0]     cfg_ref_price,
    input  logic [risk_pkg::bps_w-1:0]    cfg_price_band_bps,
    input  logic [15:0]                   cfg_token_rate,
    input  logic [15:0]                   cfg_token_max,
    input  logic [risk_pkg::qty_w-1:0]    cfg_position_limit,
    input  logic [31:0]                   cfg_stale_usec,
    input  logic                          cfg_kill,
    // Decision
    output logic                          decision_valid,
    output logic                          decision_accept,
    output risk_pkg::risk_reason_e        decision_reason,
    output logic [risk_pkg::ts_w-1:0]     decision_ts,
    input  logic                          decision_ready,
    // Statistics
    output logic [31:0]                   stat_accepts,
    output logic [31:0]                   stat_rejects
);

    import risk_pkg::*;

    // Capture to checks
    logic             cap_valid;
    logic             cap_ready;
    capture_payload_t cap_payload;
    // Checks to decide
    logic             chk_valid;
    logic             chk_ready;
    check_payload_t   chk_payload;

    // =========================================================================
    // Stage 1
    // =========================================================================

    risk_capture capture_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .bid_px        (bid_px),
        .ask_px        (ask_px),
        .bid_qty       (bid_qty),
        .ask_qty       (ask_qty),
        .book_ts       (book_ts),
        .stale         (stale),
        .event_valid   (event_valid),
        .event_ready   (event_ready),
        .timestamp_cnt (timestamp_cnt),
        .cfg_enable    (cfg_enable),
        .out_valid     (cap_valid),
        .out_payload   (cap_payload),
        .out_ready     (cap_ready)
    );

    // =========================================================================
    // Stage 2
    // =========================================================================

    risk_checks #(
        .cycles_per_usec (cycles_per_usec)
    ) checks_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .in_valid           (cap_valid),
        .in_payload         (cap_payload),
        .in_ready           (cap_ready),
        .cfg_kill           (cfg_kill),
        .cfg_ref_price      (cfg_ref_price),
        .cfg_price_band_bps (cfg_price_band_bps),
        .cfg_position_limit (cfg_position_limit),
        .cfg_stale_usec     (cfg_stale_usec),
        .out_valid          (chk_valid),
        .out_payload        (chk_payload),
        .out_ready          (chk_ready)
    );

    // =========================================================================
    // Stage 3
    // =========================================================================

    risk_decide #(
        .replenish_cycles (replenish_cycles)
    ) decide_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (chk_valid),
        .in_payload      (chk_payload),
        .in_ready        (chk_ready),
        .cfg_token_rate  (cfg_token_rate),
        .cfg_token_max   (cfg_token_max),
        .decision_valid  (decision_valid),
        .decision_accept (decision_accept),
        .decision_reason (decision_reason),
        .decision_ts     (decision_ts),
        .decision_ready  (decision_ready),
        .stat_accepts    (stat_accepts),
        .stat_rejects    (stat_rejects)
    );

endmodule : risk_gate

/* testbench/risk_gate_sva.sv */
// Bound to risk_gate; sampled on rising clk, handshake checks are off while rst_n is low
`timescale 1ns/1ps

module risk_gate_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        cfg_enable,
    input logic        event_ready,
    input logic        decision_valid,
    input logic        decision_ready,
    input logic        decision_accept,
    input logic [3:0]  decision_reason,
    input logic [63:0] decision_ts
);

    // ========================================================================
    // Reset
    // ========================================================================

    reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !decision_valid)
        else $error("decision_valid high during reset");

    // ========================================================================
    // Handshakes
    // ========================================================================

    // Offered decision stays put until taken
    decision_held: assert property (@(posedge clk) disable iff (!rst_n)
        decision_valid && !decision_ready |=> decision_valid &&
        $stable(decision_accept) && $stable(decision_reason) && $stable(decision_ts))
        else $error("decision changed before decision_ready");

    // Gate closed while disabled
    enable_gates_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_enable |-> !event_ready)
        else $error("event_ready high with cfg_enable low");

endmodule : risk_gate_sva

/* testbench/risk_gate_tb.sv */
// Random self-checking testbench; config only changes while the pipeline is empty
`timescale 1ns/1ps

module risk_gate_tb;

    import risk_pkg::*;

    localparam int refill_cycles = 64;
    localparam int usec_cycles   = 4;

    logic clk;
    logic rst_n;
    logic [px_w-1:0] bid_px;
    logic [px_w-1:0] ask_px;
    logic [qty_w-1:0] bid_qty;
    logic [qty_w-1:0] ask_qty;
    logic [ts_w-1:0] book_ts;
    logic stale;
    logic event_valid;
    logic event_ready;
    logic [ts_w-1:0] timestamp_cnt;
    logic cfg_enable;
    logic [px_w-1:0] cfg_ref_price;
    logic [bps_w-1:0] cfg_price_band_bps;
    logic [15:0] cfg_token_rate;
    logic [15:0] cfg_token_max;
    logic [qty_w-1:0] cfg_position_limit;
    logic [31:0] cfg_stale_usec;
    logic cfg_kill;
    logic decision_valid;
    logic decision_accept;
    risk_reason_e decision_reason;
    logic [ts_w-1:0] decision_ts;
    logic decision_ready;
    logic [31:0] stat_accepts;
    logic [31:0] stat_rejects;

    // Model state
    integer seed;
    int model_tokens;
    int model_accepts;
    int model_rejects;
    int run_accepts;
    int err_total;
    int test_errs;
    int test_decisions;
    int total_decisions;
    int k;
    risk_reason_e exp_reason[$];
    logic [63:0] exp_ts[$];

    risk_gate #(
        .replenish_cycles (refill_cycles),
        .cycles_per_usec  (usec_cycles)
    ) risk_gate_i (.*);

    bind risk_gate risk_gate_sva risk_gate_sva_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_enable      (cfg_enable),
        .event_ready     (event_ready),
        .decision_valid  (decision_valid),
        .decision_ready  (decision_ready),
        .decision_accept (decision_accept),
        .decision_reason (decision_reason),
        .decision_ts     (decision_ts)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    function int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // One cycle; inputs change 1 ns after the edge
    task step();
        @(posedge clk);
        #1;
        timestamp_cnt = timestamp_cnt + 64'd1;
    endtask

    task compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
            test_errs = test_errs + 1;
            err_total = err_total + 1;
        end
    endtask

    // Mid near the reference when one is set, spread kept small
    task gen_event(input int stale_q, input int qty_span);
        int mid;
        int spread;
        int age;
        if (cfg_ref_price != '0) begin
            mid = int'(cfg_ref_price) - 1000 + rand_below(2001);
        end else begin
            mid = 1000 + rand_below(200000);
        end
        spread  = rand_below(50);
        age     = rand_below(41);
        bid_px  = 32'(mid - spread);
        ask_px  = 32'(mid + spread);
        bid_qty = 32'(rand_below(qty_span));
        ask_qty = 32'(rand_below(qty_span));
        stale   = (rand_below(4) < stale_q);
        book_ts = timestamp_cnt - 64'(age);
    endtask

    // Expected outcome from the check order, token slot before position
    task push_expected();
        logic [63:0] mid;
        logic [63:0] age;
        logic [63:0] ref_px;
        logic [63:0] diff;
        risk_reason_e r;
        mid    = ({32'd0, bid_px} + {32'd0, ask_px}) >> 1;
        age    = timestamp_cnt - book_ts;
        ref_px = {32'd0, cfg_ref_price};
        diff   = (mid >= ref_px) ? mid - ref_px : ref_px - mid;
        if (cfg_kill) begin
            r = risk_kill_switch;
        end else if (stale && (age > {32'd0, cfg_stale_usec} * 64'(usec_cycles))) begin
            r = risk_stale_data;
        end else if (stale) begin
            r = risk_seq_gap;
        end else if ((ref_px != 0) && (cfg_price_band_bps != 0) &&
                     (diff * 64'd10000 > ref_px * {48'd0, cfg_price_band_bps})) begin
            r = risk_price_band;
        end else if (model_tokens == 0) begin
            r = risk_token_bucket;
        end else if ((bid_qty > cfg_position_limit) || (ask_qty > cfg_position_limit)) begin
            r = risk_position_limit;
        end else begin
            r = risk_accept;
            model_tokens = model_tokens - 1;
        end
        exp_reason.push_back(r);
        exp_ts.push_back(timestamp_cnt);
    endtask

    task check_decision();
        risk_reason_e r;
        logic [63:0] t;
        if (exp_reason.size() == 0) begin
            $display("Decision at %0t arrived with no event outstanding", $time);
            test_errs = test_errs + 1;
            err_total = err_total + 1;
        end else begin
            r = exp_reason.pop_front();
            t = exp_ts.pop_front();
            compare("decision_reason", 64'(decision_reason), 64'(r));
            compare("decision_accept", 64'(decision_accept), 64'(r == risk_accept));
            compare("decision_ts", decision_ts, t);
            if (r == risk_accept) begin
                model_accepts = model_accepts + 1;
            end else begin
                model_rejects = model_rejects + 1;
            end
        end
        // Accepts as delivered by the DUT
        if (decision_accept === 1'b1) begin
            run_accepts = run_accepts + 1;
        end
        test_decisions = test_decisions + 1;
    endtask

    // Sends n events and collects n decisions; handshakes sampled at the falling edge
    task run_events(input int n, input int stale_q, input int qty_span, input int ready_q);
        int sent;
        int got;
        int guard;
        bit taken;
        sent  = 0;
        got   = 0;
        guard = 0;
        taken = 1'b0;
        while ((got < n) && (guard < n * 40 + 200)) begin
            step();
            guard = guard + 1;
            if (taken) begin
                event_valid = 1'b0;
                taken       = 1'b0;
            end
            if (!event_valid && (sent < n) && (rand_below(4) != 0)) begin
                gen_event(stale_q, qty_span);
                event_valid = 1'b1;
            end
            decision_ready = (rand_below(4) >= ready_q);
            @(negedge clk);
            if (event_valid && event_ready) begin
                push_expected();
                sent  = sent + 1;
                taken = 1'b1;
            end
            if (decision_valid && decision_ready) begin
                check_decision();
                got = got + 1;
            end
        end
        step();
        event_valid    = 1'b0;
        decision_ready = 1'b1;
        if (got < n) begin
            $display("Timeout: only %0d of %0d decisions arrived", got, n);
            $display("Verification failed");
            $finish;
        end
    endtask

    task start_test();
        test_errs      = 0;
        test_decisions = 0;
        run_accepts    = 0;
    endtask

    task finish_test(input string name);
        total_decisions = total_decisions + test_decisions;
        $display("Test %s: %0d decisions, %0d errors", name, test_decisions, test_errs);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        seed = 32'hda66_e5d9;
        rst_n = 1'b1;
        {bid_px, ask_px, bid_qty, ask_qty, book_ts} = '0;
        stale = 1'b0;
        event_valid = 1'b0;
        timestamp_cnt = 64'd1000;
        cfg_enable = 1'b1;
        cfg_ref_price = '0;
        cfg_price_band_bps = 16'd50;
        // Bucket stays empty until the token test loads it
        cfg_token_rate = 16'd0;
        cfg_token_max = 16'd0;
        cfg_position_limit = 32'd1000;
        cfg_stale_usec = 32'd5;
        cfg_kill = 1'b0;
        decision_ready = 1'b1;
        {model_tokens, model_accepts, model_rejects, err_total, total_decisions} = '0;
        // Clean falling edge for the asynchronous reset
        #1 rst_n = 1'b0;
        repeat (4) step();
        rst_n = 1'b1;

        // Exactly K tokens, then no refill
        start_test();
        k = 3 + rand_below(4);
        cfg_token_rate = 16'(k);
        cfg_token_max  = 16'(k);
        repeat (refill_cycles + 6) step();
        cfg_token_rate = 16'd0;
        model_tokens   = k;
        run_events(k + 4, 0, 1000, 1);
        compare("token_accepts", 64'(run_accepts), 64'(k));
        finish_test("4 token bucket");

        // Effectively unlimited tokens from here on
        cfg_token_rate = 16'hffff;
        cfg_token_max  = 16'hffff;
        repeat (refill_cycles + 6) step();
        model_tokens = 65535;

        start_test();
        cfg_kill = 1'b1;
        run_events(20, 2, 1500, 1);
        cfg_kill = 1'b0;
        finish_test("1 kill switch");

        // Threshold 5 usec at 4 cycles each, ages 0..40 plus stall time
        start_test();
        run_events(30, 4, 1000, 1);
        finish_test("2 stale interlock");

        start_test();
        cfg_ref_price = 32'd100000;
        run_events(40, 0, 1500, 1);
        cfg_ref_price = '0;
        run_events(20, 0, 1500, 1);
        finish_test("3 price band and position");

        start_test();
        cfg_ref_price = 32'd100000;
        run_events(80, 1, 1500, 2);
        compare("stat_accepts", 64'(stat_accepts), 64'(model_accepts));
        compare("stat_rejects", 64'(stat_rejects), 64'(model_rejects));
        finish_test("5 back-pressure");

        // Offered events must be ignored while disabled
        start_test();
        cfg_enable = 1'b0;
        repeat (20) begin
            step();
            gen_event(1, 1500);
            event_valid = 1'b1;
            @(negedge clk);
            compare("event_ready", 64'(event_ready), 64'd0);
            compare("decision_valid", 64'(decision_valid), 64'd0);
        end
        step();
        event_valid = 1'b0;
        cfg_enable  = 1'b1;
        compare("stat_accepts", 64'(stat_accepts), 64'(model_accepts));
        compare("stat_rejects", 64'(stat_rejects), 64'(model_rejects));
        finish_test("6 enable gate");

        $display("Summary: %0d decisions checked, %0d errors", total_decisions, err_total);
        if (err_total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : risk_gate_tb

/* verilog.f */
hdl/risk_pkg.sv
hdl/risk_pipe_stage.sv
hdl/risk_capture.sv
hdl/risk_checks.sv
hdl/risk_token_bucket.sv
hdl/risk_decide.sv
hdl/risk_gate.sv
testbench/risk_gate_sva.sv
testbench/risk_gate_tb.sv

/* Makefile */
# Verilator simulation of the risk gate testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= risk_gate_tb
FILELIST  ?= verilog.f
PASS_MSG  := Verification passed

.PHONY: sim clean

# Build, run, then look for the pass message in the captured output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
